// ==== tests/frames_input.txt ====
# mode id(29 bit, base id in upper 11) ide rtr dlc data kind err
# mode: ok, stuff, crc, ack, crcdelim, eof, b2b (no idle after); err: 1 stuff 2 crc 3 form 4 ack
ok       048C0000 0 0 3 0000000000A1B2C3 frame 0
ok       15540000 0 0 0 0000000000000000 frame 0
ok       03C00000 0 0 8 0123456789ABCDEF frame 0
ok       12345678 1 0 2 000000000000BEEF frame 0
ok       0ABCDEF1 1 1 5 0000000000000000 frame 0
ok       0AA80000 0 0 C 1122334455667788 frame 0
stuff    1F800000 0 0 1 0000000000000000 error 1
ok       0C840000 0 0 1 000000000000005A frame 0
crc      11580000 0 0 2 0000000000001234 error 2
ack      04000000 0 0 1 0000000000000077 error 4
crcdelim 08000000 0 0 1 0000000000000033 error 3
eof      0C000000 0 0 1 0000000000000044 error 3
b2b      01400000 0 0 1 0000000000000099 frame 0
ok       01800000 0 0 2 000000000000CAFE frame 0

// ==== src.f ====
common/can_bus_pkg.sv
common/can_frame_pkg.sv
src/can_bit_destuff.sv
src/can_crc15.sv
decoder/can_frame_fsm.sv
src/can_decoder_top.sv
tests/can_decoder_assert.sv
tests/can_decoder_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module can_decoder_tb -f src.f -o can_decoder_sim
	./obj_dir/can_decoder_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/can_decoder_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module can_decoder_tb;
	import can_frame_pkg::*;

	localparam int max_lines = 32;
	localparam int idle_bits = 14;		// More than bus_idle_len, so recovery always ends

	logic clock;
	logic reset;
	logic rx_bit;
	logic sample_point;
	logic frame_valid;
	frame_id_t frame_id;
	logic frame_ide;
	logic frame_rtr;
	dlc_t frame_dlc;
	payload_t frame_data;
	logic error_valid;
	error_code_t error_code;

	// Prepared lines of the input file
	string line_mode [max_lines];
	logic [255:0] line_bits [max_lines];	// Bit 0 goes out first
	int line_len [max_lines];
	logic line_is_frame [max_lines];
	logic [28:0] exp_id [max_lines];
	logic exp_ide [max_lines];
	logic exp_rtr [max_lines];
	logic [3:0] exp_dlc [max_lines];
	logic [63:0] exp_data [max_lines];
	logic [2:0] exp_err [max_lines];
	int num_lines;

	logic raw [0:255];		// Unstuffed frame under construction
	int raw_len;
	int pending [$];		// Lines whose result is still due
	int mon_idx;
	int cycle_count = 0;
	int cycle_limit = 1000000;
	int total_bits;

	can_decoder_top DUT (
		.clock(clock),
		.reset(reset),
		.rx_bit(rx_bit),
		.sample_point(sample_point),
		.frame_valid(frame_valid),
		.frame_id(frame_id),
		.frame_ide(frame_ide),
		.frame_rtr(frame_rtr),
		.frame_dlc(frame_dlc),
		.frame_data(frame_data),
		.error_valid(error_valid),
		.error_code(error_code)
	);

	always #4 clock = ~clock;	// 8 ns period

	// ==================================================
	// Failure reporting
	// ==================================================
	task automatic report_failure(input string msg);
	begin
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1);
	end
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
	begin
		if (got !== exp)
			report_failure($sformatf("** Error: %s = %h, expected %h", name, got, exp));
	end
	endtask

	// ==================================================
	// Frame encoder, CAN rules
	// ==================================================
	task automatic add_raw(input logic b);
	begin
		raw[raw_len] = b;
		raw_len++;
	end
	endtask

	// CRC-15 over SOF through data, generator 0x4599
	function automatic logic [14:0] crc_of(input int len);
		logic [14:0] crc;
		logic nxt;
		crc = '0;
		for (int i = 0; i < len; i++)
		begin
			nxt = raw[i] ^ crc[14];
			crc = {crc[13:0], 1'b0};
			if (nxt)
				crc = crc ^ 15'h4599;
		end
		return crc;
	endfunction

	task automatic build_line(input int idx, input string mode, input logic [28:0] id,
		input logic ide, input logic rtr, input logic [3:0] dlc, input logic [63:0] data);
		int nbytes;
		int data_start;
		int run;
		int n;
		logic last;
		logic b;
		logic [14:0] crc;
		logic [255:0] bits;
	begin
		raw_len = 0;
		add_raw(1'b0);					// SOF
		for (int i = 28; i >= 18; i--)
			add_raw(id[i]);
		if (ide)
		begin
			add_raw(1'b1);				// SRR
			add_raw(1'b1);				// IDE
			for (int i = 17; i >= 0; i--)
				add_raw(id[i]);
			add_raw(rtr);
			add_raw(1'b0);				// r1
			add_raw(1'b0);				// r0
		end
		else
		begin
			add_raw(rtr);
			add_raw(1'b0);				// IDE
			add_raw(1'b0);				// r0
		end
		for (int i = 3; i >= 0; i--)
			add_raw(dlc[i]);
		nbytes = rtr ? 0 : ((dlc > 4'd8) ? 8 : int'(dlc));
		data_start = raw_len;
		for (int i = nbytes * 8 - 1; i >= 0; i--)
			add_raw(data[i]);
		crc = crc_of(raw_len);
		for (int i = 14; i >= 0; i--)
			add_raw(crc[i]);
		if (mode == "crc")
			raw[data_start] = ~raw[data_start];	// Corrupt after the CRC was taken
		bits = '0;
		n = 0;
		if (mode == "stuff")
		begin
			for (int i = 0; i < 12; i++)	// SOF and identifier, never stuffed
			begin
				bits[n] = raw[i];
				n++;
			end
		end
		else
		begin
			last = raw[0];
			run = 0;
			for (int i = 0; i < raw_len; i++)
			begin
				b = raw[i];
				bits[n] = b;
				n++;
				if (b == last)
					run++;
				else
				begin
					last = b;
					run = 1;
				end
				if (run == 5)
				begin
					bits[n] = ~b;		// Stuff bit, may follow the last CRC bit
					n++;
					last = ~b;
					run = 1;
				end
			end
			bits[n] = (mode == "crcdelim") ? 1'b0 : 1'b1;
			n++;
			bits[n] = (mode == "ack") ? 1'b1 : 1'b0;	// ACK slot
			n++;
			bits[n] = 1'b1;				// ACK delimiter
			n++;
			for (int i = 0; i < 7; i++)
			begin
				bits[n] = (mode == "eof" && i == 3) ? 1'b0 : 1'b1;
				n++;
			end
			for (int i = 0; i < 2; i++)	// Intermission
			begin
				bits[n] = 1'b1;
				n++;
			end
		end
		line_bits[idx] = bits;
		line_len[idx] = n;
	end
	endtask

	// ==================================================
	// Input file
	// ==================================================
	task automatic read_input();
		int fd;
		int r;
		int nbytes;
		string text;
		string mode;
		string kind;
		logic [28:0] id;
		logic ide;
		logic rtr;
		logic [3:0] dlc;
		logic [63:0] data;
		logic [2:0] err;
		logic [63:0] held;
	begin
		held = '0;
		num_lines = 0;
		fd = $fopen("tests/frames_input.txt", "r");
		if (fd == 0)
			report_failure("Cannot open tests/frames_input.txt");
		while (!$feof(fd))
		begin
			r = $fgets(text, fd);
			if (r > 0 && text.len() > 1 && text.getc(0) != "#")
			begin
				r = $sscanf(text, "%s %h %h %h %h %h %s %h",
					mode, id, ide, rtr, dlc, data, kind, err);
				if (r == 8 && num_lines < max_lines)
				begin
					line_mode[num_lines] = mode;
					build_line(num_lines, mode, id, ide, rtr, dlc, data);
					line_is_frame[num_lines] = (kind == "frame");
					exp_id[num_lines] = id;
					exp_ide[num_lines] = ide;
					exp_rtr[num_lines] = rtr;
					exp_dlc[num_lines] = (dlc > 4'd8) ? 4'd8 : dlc;
					nbytes = rtr ? 0 : int'(exp_dlc[num_lines]);
					if (kind == "frame" && nbytes == 8)
						held = data;
					else if (kind == "frame" && nbytes > 0)
						held = data & ((64'd1 << (nbytes * 8)) - 64'd1);
					exp_data[num_lines] = held;	// No data field keeps the last payload
					exp_err[num_lines] = err;
					num_lines++;
				end
			end
		end
		$fclose(fd);
	end
	endtask

	// One bit time, strobe after a random gap
	task automatic send_bit(input logic b);
		int gap;
	begin
		gap = 2 + int'($urandom % 5);
		repeat (gap) @(posedge clock);
		rx_bit <= b;
		sample_point <= 1'b1;
		@(posedge clock);
		sample_point <= 1'b0;
	end
	endtask

	// ==================================================
	// Result monitor
	// ==================================================
	always @(posedge clock)
	begin
		if (!reset && (frame_valid || error_valid))
		begin
			if (pending.size() == 0)
				report_failure("A result was reported with no frame on the bus");
			mon_idx = pending.pop_front();
			if (frame_valid && !line_is_frame[mon_idx])
				report_failure($sformatf("Line %0d decoded as a frame, an error was expected",
					mon_idx));
			else if (error_valid && line_is_frame[mon_idx])
				report_failure($sformatf("Line %0d reported error code %0d, a frame was expected",
					mon_idx, error_code));
			else if (frame_valid)
			begin
				check_value("frame_id", 64'(frame_id), 64'(exp_id[mon_idx]));
				check_value("frame_ide", 64'(frame_ide), 64'(exp_ide[mon_idx]));
				check_value("frame_rtr", 64'(frame_rtr), 64'(exp_rtr[mon_idx]));
				check_value("frame_dlc", 64'(frame_dlc), 64'(exp_dlc[mon_idx]));
				check_value("frame_data", frame_data, exp_data[mon_idx]);
			end
			else
				check_value("error_code", 64'(error_code), 64'(exp_err[mon_idx]));
		end
	end

	// Run limit
	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
			report_failure("Timeout, the run did not finish within its cycle limit");
	end

	// ==================================================
	// Main sequence
	// ==================================================
	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		rx_bit = 1'b1;
		sample_point = 1'b0;
		void'($urandom(4));
		read_input();
		total_bits = 4;
		for (int l = 0; l < num_lines; l++)
			total_bits += line_len[l] + ((line_mode[l] == "b2b") ? 0 : idle_bits);
		cycle_limit = total_bits * 6 * 2 + 100;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		repeat (4) send_bit(1'b1);
		for (int l = 0; l < num_lines; l++)
		begin
			pending.push_back(l);
			for (int i = 0; i < line_len[l]; i++)
				send_bit(line_bits[l][i]);
			if (line_mode[l] != "b2b")		// Next SOF follows the intermission directly
			begin
				repeat (idle_bits) send_bit(1'b1);
				repeat (4) @(posedge clock);
				if (pending.size() != 0)
					report_failure($sformatf("Line %0d produced no result", l));
			end
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/can_decoder_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module can_decoder_assert (
	input logic clock,
	input logic reset,
	input logic frame_valid,
	input logic error_valid,
	input logic [3:0] frame_dlc
);

	// ==================================================
	// Result pulse rules
	// ==================================================
	a_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(frame_valid && error_valid))
		else $error("frame_valid and error_valid high together");

	a_frame_pulse: assert property (@(posedge clock) disable iff (reset)
		frame_valid |=> !frame_valid)
		else $error("frame_valid longer than one cycle");

	a_error_pulse: assert property (@(posedge clock) disable iff (reset)
		error_valid |=> !error_valid)
		else $error("error_valid longer than one cycle");

	a_dlc_clip: assert property (@(posedge clock) disable iff (reset)
		frame_valid |-> (frame_dlc <= 4'd8))
		else $error("frame_dlc above 8");

	// Quiet after the first clock out of reset
	a_reset_quiet: assert property (@(posedge clock)
		$fell(reset) |=> (!frame_valid && !error_valid))
		else $error("Result pulse right after reset");

endmodule

bind can_decoder_top can_decoder_assert u_assert (
	.clock(clock),
	.reset(reset),
	.frame_valid(frame_valid),
	.error_valid(error_valid),
	.frame_dlc(frame_dlc)
);

`default_nettype wire

// ==== src/can_decoder_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module can_decoder_top (
	input logic clock,
	input logic reset,
	input logic rx_bit,				// Bus level, 1 = recessive
	input logic sample_point,		// One strobe per bit time
	output logic frame_valid,
	output can_frame_pkg::frame_id_t frame_id,
	output logic frame_ide,
	output logic frame_rtr,
	output can_frame_pkg::dlc_t frame_dlc,
	output can_frame_pkg::payload_t frame_data,
	output logic error_valid,
	output can_frame_pkg::error_code_t error_code
);
	import can_frame_pkg::*;

	// Destuffer to FSM
	logic bit_valid;
	logic bit_value;
	logic bit_stuffed;
	logic stuff_error;
	logic stuff_enable;		// Back from the FSM

	// FSM to CRC
	logic crc_clear;
	logic crc_shift;
	logic crc_bit;
	crc_t crc_value;

	// ==================================================
	// Stage 1, sample and destuff
	// ==================================================
	can_bit_destuff u_destuff (
		.clock(clock),
		.reset(reset),
		.rx_bit(rx_bit),
		.sample_point(sample_point),
		.stuff_enable(stuff_enable),
		.bit_valid(bit_valid),
		.bit_value(bit_value),
		.bit_stuffed(bit_stuffed),
		.stuff_error(stuff_error)
	);

	// ==================================================
	// Stage 2, frame FSM with its CRC
	// ==================================================
	can_frame_fsm u_fsm (
		.clock(clock),
		.reset(reset),
		.bit_valid(bit_valid),
		.bit_value(bit_value),
		.bit_stuffed(bit_stuffed),
		.stuff_error(stuff_error),
		.crc_value(crc_value),
		.stuff_enable(stuff_enable),
		.crc_clear(crc_clear),
		.crc_shift(crc_shift),
		.crc_bit(crc_bit),
		.frame_valid(frame_valid),
		.frame_id(frame_id),
		.frame_ide(frame_ide),
		.frame_rtr(frame_rtr),
		.frame_dlc(frame_dlc),
		.frame_data(frame_data),
		.error_valid(error_valid),
		.error_code(error_code)
	);

	can_crc15 u_crc (
		.clock(clock),
		.reset(reset),
		.crc_clear(crc_clear),
		.crc_shift(crc_shift),
		.crc_bit(crc_bit),
		.crc_value(crc_value)	// Ready one cycle after each shift
	);

endmodule

`default_nettype wire

// ==== decoder/can_frame_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module can_frame_fsm (
	input logic clock,
	input logic reset,
	input logic bit_valid,
	input logic bit_value,
	input logic bit_stuffed,
	input logic stuff_error,
	input can_frame_pkg::crc_t crc_value,
	output logic stuff_enable,
	output logic crc_clear,
	output logic crc_shift,
	output logic crc_bit,
	output logic frame_valid,
	output can_frame_pkg::frame_id_t frame_id,
	output logic frame_ide,
	output logic frame_rtr,
	output can_frame_pkg::dlc_t frame_dlc,
	output can_frame_pkg::payload_t frame_data,
	output logic error_valid,
	output can_frame_pkg::error_code_t error_code
);
	import can_bus_pkg::*;
	import can_frame_pkg::*;

	frame_state_t state, next_state;
	logic [5:0] cnt, next_cnt;	// Shared bit counter
	error_code_t bit_error;
	logic frame_done;
	logic take;					// Real frame bit, stuff bits dropped

	// Field capture
	frame_id_t id_shift;		// Base bits land low first
	logic rtr_srr;				// RTR in base frames, SRR in extended
	logic ide;
	logic rtr;
	dlc_t dlc;
	dlc_t dlc_full;
	dlc_t dlc_clip;
	logic [6:0] data_bits;		// Payload length in bits
	payload_t payload;
	crc_t rx_crc;

	assign take = bit_valid & ~bit_stuffed & ~stuff_error;
	assign dlc_full = {dlc[dlc_width-2:0], bit_value};
	assign dlc_clip = (dlc_full > dlc_t'(max_data_bytes)) ? dlc_t'(max_data_bytes) : dlc_full;
	assign data_bits = {dlc, 3'b000};

	// Destuffer and CRC side
	assign stuff_enable = (state inside {[st_id_a:st_crc_delim]});
	assign crc_clear = take & (state == st_idle) & ~bit_value;	// SOF
	assign crc_shift = take & (state inside {[st_id_a:st_data]});
	assign crc_bit = bit_value;

	// ==================================================
	// Next state and bit checks
	// ==================================================
	always_comb
	begin
		next_state = state;
		next_cnt = cnt;
		bit_error = err_none;
		frame_done = 1'b0;
		if (bit_valid && stuff_error)
			bit_error = err_stuff;
		else if (take)
		begin
			next_cnt = cnt + 6'd1;
			case (state)
				st_idle:
					if (!bit_value)
					begin
						next_state = st_id_a;	// Dominant SOF
						next_cnt = '0;
					end
				st_id_a:
					if (cnt == 6'(id_a_len - 1))
						next_state = st_rtr_srr;
				st_rtr_srr:
					next_state = st_ide;
				st_ide:
					if (!bit_value)
						next_state = st_res0;	// Base frame, r0 follows
					else if (!rtr_srr)
						bit_error = err_form;	// SRR must be recessive
					else
					begin
						next_state = st_id_b;
						next_cnt = '0;
					end
				st_id_b:
					if (cnt == 6'(id_b_len - 1))
						next_state = st_rtr;
				st_rtr:
					next_state = st_res1;
				st_res1:
					next_state = st_res0;
				st_res0:
				begin
					next_state = st_dlc;
					next_cnt = '0;
				end
				st_dlc:
					if (cnt == 6'(dlc_len - 1))
					begin
						next_cnt = '0;
						next_state = (rtr || dlc_clip == '0) ? st_crc : st_data;
					end
				st_data:
					if ({1'b0, cnt} == data_bits - 7'd1)
					begin
						next_state = st_crc;
						next_cnt = '0;
					end
				st_crc:
					if (cnt == 6'(crc_len - 1))
						next_state = st_crc_delim;
				st_crc_delim:
					if (rx_crc != crc_value)
						bit_error = err_crc;
					else if (!bit_value)
						bit_error = err_form;
					else
						next_state = st_ack_slot;
				st_ack_slot:
					if (bit_value)
						bit_error = err_ack;	// Nobody acknowledged
					else
						next_state = st_ack_delim;
				st_ack_delim:
					if (!bit_value)
						bit_error = err_form;
					else
					begin
						next_state = st_eof;
						next_cnt = '0;
					end
				st_eof:
					if (!bit_value)
						bit_error = err_form;
					else if (cnt == 6'(eof_len - 1))
					begin
						frame_done = 1'b1;
						next_state = st_intermission;
						next_cnt = '0;
					end
				st_intermission:
					if (!bit_value)
						bit_error = err_form;	// No overload frames here
					else if (cnt == 6'(intermission_len - 1))
						next_state = st_idle;
				st_recover:
					if (!bit_value)
						next_cnt = '0;			// Bus still busy
					else if (cnt == 6'(bus_idle_len - 1))
						next_state = st_idle;
				default:
					next_state = st_idle;
			endcase
		end
		if (bit_error != err_none)
		begin
			next_state = st_recover;
			next_cnt = '0;
		end
	end

	// State, counter and result pulses
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= st_idle;
			cnt <= '0;
			frame_valid <= 1'b0;
			error_valid <= 1'b0;
			error_code <= err_none;
		end
		else
		begin
			state <= next_state;
			cnt <= next_cnt;
			frame_valid <= frame_done;
			error_valid <= (bit_error != err_none);
			if (bit_error != err_none)
				error_code <= bit_error;
		end
	end

	// ==================================================
	// Field capture and held results
	// ==================================================
	always_ff @(posedge clock)
	begin
		if (take)
		begin
			case (state)
				st_id_a, st_id_b:
					id_shift <= {id_shift[frame_id_width-2:0], bit_value};
				st_rtr_srr:
					rtr_srr <= bit_value;
				st_ide:
				begin
					ide <= bit_value;
					rtr <= rtr_srr;		// Final for base frames
				end
				st_rtr:
					rtr <= bit_value;
				st_dlc:
					dlc <= (cnt == 6'(dlc_len - 1)) ? dlc_clip : dlc_full;
				st_data:
					payload <= {payload[payload_width-2:0], bit_value};
				st_crc:
					rx_crc <= {rx_crc[crc_width-2:0], bit_value};
				default:
					;
			endcase
			if (state == st_dlc && next_state == st_data)
				payload <= '0;			// Short payloads come out right aligned
		end
		if (frame_done)
		begin
			frame_id <= ide ? id_shift : {id_shift[id_a_len-1:0], {id_b_len{1'b0}}};
			frame_ide <= ide;
			frame_rtr <= rtr;
			frame_dlc <= dlc;
			frame_data <= payload;	// Unchanged when no data field was received
		end
	end

endmodule

`default_nettype wire

// ==== src/can_crc15.sv ====
`timescale 1ns/100ps
`default_nettype none

module can_crc15 (
	input logic clock,
	input logic reset,
	input logic crc_clear,		// Start of frame
	input logic crc_shift,		// One destuffed frame bit
	input logic crc_bit,
	output can_frame_pkg::crc_t crc_value
);
	import can_frame_pkg::*;

	logic feedback;

	// MSB out, compared against the incoming bit
	assign feedback = crc_value[crc_width-1] ^ crc_bit;

	// ==================================================
	// LFSR, one step per frame bit
	// ==================================================
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			crc_value <= '0;
		else if (crc_clear)
			crc_value <= '0;	// A zero SOF leaves a zero register unchanged
		else if (crc_shift)
			crc_value <= {crc_value[crc_width-2:0], 1'b0} ^ (feedback ? crc_poly : '0);
	end

endmodule

`default_nettype wire

// ==== src/can_bit_destuff.sv ====
`timescale 1ns/100ps
`default_nettype none

module can_bit_destuff (
	input logic clock,
	input logic reset,
	input logic rx_bit,			// 1 = recessive
	input logic sample_point,	// One strobe per bit time
	input logic stuff_enable,	// From the frame FSM
	output logic bit_valid,
	output logic bit_value,
	output logic bit_stuffed,
	output logic stuff_error
);
	import can_bus_pkg::*;

	logic run_bit;			// Level of the current run
	logic [2:0] run_len;	// Equal bits seen so far
	logic run_full;
	logic is_stuff;
	logic is_sixth;

	assign run_full = (run_len == 3'(stuff_run_len));
	assign is_stuff = stuff_enable & run_full & (rx_bit != run_bit);	// Opposite bit ends the run
	assign is_sixth = stuff_enable & run_full & (rx_bit == run_bit);	// Sixth equal bit

	// ==================================================
	// Run history and flags
	// ==================================================
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			bit_valid <= 1'b0;
			bit_stuffed <= 1'b0;
			stuff_error <= 1'b0;
			run_bit <= 1'b1;
			run_len <= '0;
		end
		else
		begin
			bit_valid <= sample_point;	// One cycle behind the strobe
			bit_stuffed <= sample_point & is_stuff;
			stuff_error <= sample_point & is_sixth;
			if (sample_point)
			begin
				if (!stuff_enable || is_stuff || (rx_bit != run_bit))
				begin
					run_bit <= rx_bit;	// Outside stuffing only the last bit counts, SOF included
					run_len <= 3'd1;
				end
				else if (!run_full)
					run_len <= run_len + 3'd1;
			end
		end
	end

	// Sampled level
	always_ff @(posedge clock)
	begin
		if (sample_point)
			bit_value <= rx_bit;
	end

endmodule

`default_nettype wire

// ==== common/can_frame_pkg.sv ====
`default_nettype none

// ==================================================
// Frame-level types of the decoder
// ==================================================
package can_frame_pkg;

	// Result widths
	localparam int frame_id_width = 29;	// 11 base + 18 extension
	localparam int dlc_width = 4;
	localparam int payload_width = 64;	// Eight bytes, right aligned
	localparam int crc_width = 15;

	typedef logic [frame_id_width-1:0] frame_id_t;
	typedef logic [dlc_width-1:0] dlc_t;
	typedef logic [payload_width-1:0] payload_t;
	typedef logic [crc_width-1:0] crc_t;

	// CAN CRC-15 generator, x^15 term implicit
	localparam crc_t crc_poly = 15'h4599;

	// Frame walk, st_id_a up to st_crc_delim is the stuffed region
	typedef enum logic [4:0] {
		st_idle, st_id_a, st_rtr_srr, st_ide, st_id_b, st_rtr,
		st_res1, st_res0, st_dlc, st_data, st_crc, st_crc_delim,
		st_ack_slot, st_ack_delim, st_eof, st_intermission, st_recover
	} frame_state_t;

	// Error classes, one per failed frame
	typedef enum logic [2:0] {
		err_none, err_stuff, err_crc, err_form, err_ack
	} error_code_t;

endpackage

`default_nettype wire

// ==== common/can_bus_pkg.sv ====
`default_nettype none

// ==================================================
// Bit-level constants of the CAN bus
// ==================================================
package can_bus_pkg;

	// Bit stuffing
	localparam int stuff_run_len = 5;	// Equal bits before a stuff bit

	// Field lengths in bits
	localparam int id_a_len = 11;		// Base identifier
	localparam int id_b_len = 18;		// Identifier extension
	localparam int dlc_len = 4;			// Data length code
	localparam int crc_len = 15;		// CRC sequence

	// Frame tail
	localparam int eof_len = 7;			// End of frame, all recessive
	localparam int intermission_len = 2;	// Third bit may already be the next SOF

	// Error recovery
	localparam int bus_idle_len = 11;	// Recessive bits that mark a free bus

	// Payload limit
	localparam int max_data_bytes = 8;	// DLC values above this are clipped

endpackage

`default_nettype wire
